// File: init_defs.svh
`ifndef INIT_DEFS_SVH
`define INIT_DEFS_SVH

// 7-bit bus address of the codec, 0x34 on the wire with the write bit
`define CODEC_DEV_ADDR 7'h1A

// Entries in the power-up register table
`define INIT_NUM_REGS 7

// System clocks per half bit-period on the control bus
// Any value of 1 or more works
`define I2C_PHASE_CYCLES 4

`endif

// File: codec_init_pkg.sv
`default_nettype none

package codec_init_pkg;

    // One codec register write, 7-bit address and 9-bit value
    typedef struct packed {
        logic [6:0] addr;
        logic [8:0] value;
    } codec_reg_write_t;

    // Three bytes of a write frame, first byte on the bus in the MSBs
    typedef struct packed {
        logic [7:0] dev_byte;   // Device address and write bit
        logic [7:0] reg_byte;   // Register address and value bit 8
        logic [7:0] data_byte;  // Value bits 7 to 0
    } i2c_frame_t;

    // Bus engine states
    typedef enum logic [2:0] {
        ENG_IDLE      = 3'd0,
        ENG_START     = 3'd1,
        ENG_BIT_LOW   = 3'd2,
        ENG_BIT_HIGH  = 3'd3,
        ENG_STOP_LOW  = 3'd4,
        ENG_STOP_HIGH = 3'd5
    } eng_state_e;

endpackage

`default_nettype wire

// File: i2c_word_if.sv
`timescale 1ns/1ps
`default_nettype none

// One write frame handed from the sequencer to the bus engine
interface i2c_word_if
    import codec_init_pkg::*;
();

    logic       req;    // Single-cycle request
    i2c_frame_t frame;  // Stable from req until done
    logic       done;   // Single-cycle, after the stop
    logic       nack;   // Valid with done

    modport seq (
        output req,
        output frame,
        input  done,
        input  nack
    );

    modport eng (
        input  req,
        input  frame,
        output done,
        output nack
    );

endinterface

`default_nettype wire

// File: i2c_write_engine.sv
`timescale 1ns/1ps
`default_nettype none

`include "init_defs.svh"

module i2c_write_engine
    import codec_init_pkg::*;
(
    input  wire logic i_clk,
    input  wire logic i_rst_n,
    input  wire logic i_sdat,
    output logic      o_sclk,
    output logic      o_sdat,
    output logic      o_oen,
    i2c_word_if.eng   word
);

    localparam int PHASE_W = (`I2C_PHASE_CYCLES > 1) ? $clog2(`I2C_PHASE_CYCLES) : 1;
    localparam logic [PHASE_W-1:0] PHASE_LAST = PHASE_W'(`I2C_PHASE_CYCLES - 1);
    localparam logic [4:0] LAST_SLOT = 5'd27;

    eng_state_e         state_q;
    logic [PHASE_W-1:0] phase_q;
    logic [4:0]         slot_q;     // 0 is the setup phase, 1..27 the bit-slots
    logic [23:0]        shift_q;
    logic               sclk_q;
    logic               sdat_q;
    logic               oen_q;
    logic               nack_q;
    logic               done_q;

    logic               phase_end;
    logic [4:0]         next_slot;
    logic               slot_step;  // Move into the low phase of the next slot

    // Slots 9, 18 and 27 belong to the device
    function automatic logic is_ack(input logic [4:0] slot);
        return (slot == 5'd9) || (slot == 5'd18) || (slot == 5'd27);
    endfunction

    assign phase_end = (phase_q == PHASE_LAST);
    assign next_slot = slot_q + 5'd1;

    assign slot_step = phase_end &&
                       (((state_q == ENG_BIT_LOW) && (slot_q == 5'd0)) ||
                        ((state_q == ENG_BIT_HIGH) && (slot_q != LAST_SLOT)));

    // Half bit-period divider, parked while idle
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            phase_q <= '0;
        end else if ((state_q == ENG_IDLE) || phase_end) begin
            phase_q <= '0;
        end else begin
            phase_q <= phase_q + 1'b1;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q <= ENG_IDLE;
            slot_q  <= '0;
            sclk_q  <= 1'b1;
            sdat_q  <= 1'b1;
            oen_q   <= 1'b1;
            nack_q  <= 1'b0;
            done_q  <= 1'b0;
        end else begin
            done_q <= 1'b0;

            // Device answer is taken at the end of the high phase
            if ((state_q == ENG_BIT_HIGH) && phase_end && is_ack(slot_q)) begin
                nack_q <= nack_q | i_sdat;
            end

            case (state_q)
                ENG_IDLE: begin
                    if (word.req) begin
                        state_q <= ENG_START;
                        sdat_q  <= 1'b0;        // Start condition, clock stays high
                        slot_q  <= '0;
                        nack_q  <= 1'b0;
                    end
                end
                ENG_START: begin
                    if (phase_end) begin
                        state_q <= ENG_BIT_LOW; // Setup phase with slot 0
                        sclk_q  <= 1'b0;
                    end
                end
                ENG_BIT_LOW: begin
                    if (phase_end && (slot_q != 5'd0)) begin
                        state_q <= ENG_BIT_HIGH;
                        sclk_q  <= 1'b1;
                    end
                end
                ENG_BIT_HIGH: begin
                    if (phase_end && (slot_q == LAST_SLOT)) begin
                        state_q <= ENG_STOP_LOW;
                        sdat_q  <= 1'b0;        // Already low from the ack slot
                        oen_q   <= 1'b1;
                    end
                end
                ENG_STOP_LOW: begin
                    if (phase_end) begin
                        state_q <= ENG_STOP_HIGH;
                        sdat_q  <= 1'b1;        // Stop condition
                    end
                end
                ENG_STOP_HIGH: begin
                    if (phase_end) begin
                        state_q <= ENG_IDLE;
                        done_q  <= 1'b1;
                    end
                end
                default: begin
                    state_q <= ENG_IDLE;
                end
            endcase

            if (slot_step) begin
                state_q <= ENG_BIT_LOW;
                sclk_q  <= 1'b0;
                slot_q  <= next_slot;
                if (is_ack(next_slot)) begin
                    oen_q  <= 1'b0;             // Release the line for the whole slot
                    sdat_q <= 1'b0;
                end else begin
                    oen_q  <= 1'b1;
                    sdat_q <= shift_q[23];
                end
            end
        end
    end

    // Frame bits, MSB first
    always_ff @(posedge i_clk) begin
        if ((state_q == ENG_IDLE) && word.req) begin
            shift_q <= word.frame;
        end else if (slot_step && !is_ack(next_slot)) begin
            shift_q <= {shift_q[22:0], 1'b0};
        end
    end

    assign o_sclk    = sclk_q;
    assign o_sdat    = sdat_q;
    assign o_oen     = oen_q;
    assign word.done = done_q;
    assign word.nack = nack_q;

    // Sequencer must wait for done before the next request
    assert property (@(posedge i_clk) disable iff (!i_rst_n)
        word.req |-> (state_q == ENG_IDLE))
    else $error("frame request while the engine is busy");

    // Data moves under a high clock only for start and stop
    assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (o_sclk && $past(o_sclk) &&
         !(state_q inside {ENG_START, ENG_STOP_LOW, ENG_STOP_HIGH}))
        |-> $stable(o_sdat))
    else $error("data line changed while the clock was high");

endmodule

`default_nettype wire

// File: codec_init_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "init_defs.svh"

module codec_init_sequencer
    import codec_init_pkg::*;
(
    input  wire logic i_clk,
    input  wire logic i_rst_n,
    input  wire logic i_start,
    output logic      o_finished,
    output logic      o_error,
    i2c_word_if.seq   word
);

    localparam logic [2:0] LAST_IDX = 3'(`INIT_NUM_REGS - 1);

    // Power-up register table, written in this order
    localparam codec_reg_write_t INIT_TABLE [`INIT_NUM_REGS] = '{
        '{addr: 7'h0F, value: 9'h000},  // Reset
        '{addr: 7'h04, value: 9'h015},  // Analogue path
        '{addr: 7'h05, value: 9'h000},  // Digital path
        '{addr: 7'h06, value: 9'h000},  // Power down
        '{addr: 7'h07, value: 9'h042},  // Interface format
        '{addr: 7'h08, value: 9'h019},  // Sampling
        '{addr: 7'h09, value: 9'h001}   // Active
    };

    logic             start_q;
    logic             start_rise;
    logic             busy_q;         // Sequence running
    logic             outstanding_q;  // Frame handed to the engine
    logic [2:0]       idx_q;
    logic             req_q;
    logic             finished_q;
    logic             error_q;
    codec_reg_write_t entry;

    assign start_rise = i_start && !start_q;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            start_q       <= 1'b0;
            busy_q        <= 1'b0;
            outstanding_q <= 1'b0;
            idx_q         <= '0;
            req_q         <= 1'b0;
            finished_q    <= 1'b0;
            error_q       <= 1'b0;
        end else begin
            start_q <= i_start;
            req_q   <= 1'b0;

            if (req_q) begin
                outstanding_q <= 1'b1;
            end

            if (start_rise && !busy_q) begin
                busy_q     <= 1'b1;
                idx_q      <= '0;
                req_q      <= 1'b1;
                finished_q <= 1'b0;    // Fresh run clears both levels
                error_q    <= 1'b0;
            end else if (word.done) begin
                outstanding_q <= 1'b0;
                if (word.nack) begin
                    busy_q  <= 1'b0;   // Rest of the table is dropped
                    error_q <= 1'b1;
                end else if (idx_q == LAST_IDX) begin
                    busy_q     <= 1'b0;
                    finished_q <= 1'b1;
                end else begin
                    idx_q <= idx_q + 3'd1;
                    req_q <= 1'b1;
                end
            end
        end
    end

    assign entry = INIT_TABLE[idx_q];

    // Frame follows the index, so it holds until done
    assign word.frame = '{
        dev_byte:  {`CODEC_DEV_ADDR, 1'b0},
        reg_byte:  {entry.addr, entry.value[8]},
        data_byte: entry.value[7:0]
    };

    assign word.req   = req_q;
    assign o_finished = finished_q;
    assign o_error    = error_q;

    // Engine answers only frames that were requested
    assert property (@(posedge i_clk) disable iff (!i_rst_n)
        word.done |-> outstanding_q)
    else $error("done without an outstanding frame");

endmodule

`default_nettype wire

// File: codec_init_top.sv
`timescale 1ns/1ps
`default_nettype none

module codec_init_top (
    input  wire logic i_clk,
    input  wire logic i_rst_n,
    input  wire logic i_start,   // Rising edge starts the table
    input  wire logic i_sdat,    // Data line as seen on the bus
    output logic      o_sclk,
    output logic      o_sdat,
    output logic      o_oen,     // High while the block drives the data line
    output logic      o_finished,
    output logic      o_error
);

    i2c_word_if word_if ();

    // Table walker
    codec_init_sequencer codec_init_sequencer_inst (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_start    (i_start),
        .o_finished (o_finished),
        .o_error    (o_error),
        .word       (word_if.seq)
    );

    // Bus-level write frames
    i2c_write_engine i2c_write_engine_inst (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_sdat  (i_sdat),
        .o_sclk  (o_sclk),
        .o_sdat  (o_sdat),
        .o_oen   (o_oen),
        .word    (word_if.eng)
    );

endmodule

`default_nettype wire

// File: tb_codec_init.sv
`timescale 1ns/1ps
`default_nettype none

`include "init_defs.svh"

module tb_codec_init
    import codec_init_pkg::*;
();

    localparam int PHASE        = `I2C_PHASE_CYCLES;
    localparam int NUM_RUNS     = 8;
    localparam int FRAME_CYCLES = 58 * PHASE;
    localparam int GAP_MAX      = 48;
    // Idle gap, start pulses and settle time on top of the frames of one run
    localparam int RUN_SLACK    = GAP_MAX + FRAME_CYCLES + 2 * PHASE + 40;
    localparam int TIMEOUT_CYCLES =
        (NUM_RUNS * (`INIT_NUM_REGS * FRAME_CYCLES + RUN_SLACK) + 20) * 12 / 10;

    // Reference copy of the codec register table
    localparam logic [6:0] MODEL_ADDR [7] = '{7'h0F, 7'h04, 7'h05, 7'h06, 7'h07, 7'h08, 7'h09};
    localparam logic [8:0] MODEL_VALUE [7] = '{9'h000, 9'h015, 9'h000, 9'h000,
                                               9'h042, 9'h019, 9'h001};

    logic i_clk;
    logic i_rst_n;
    logic i_start;
    logic i_sdat = 1'b1;
    logic o_sclk;
    logic o_sdat;
    logic o_oen;
    logic o_finished;
    logic o_error;

    logic [31:0] rng_state = 32'd79;
    int unsigned cycle_count = 0;

    // Device model state
    logic        dev_oen_q;
    logic [7:0]  ack_total;     // Ack slots seen since reset
    logic        nack_armed = 1'b0;
    logic [7:0]  nack_target = '0;

    // Bus monitor state
    logic        mon_sclk_q;
    logic        mon_sdat_q;
    logic        mon_oen_q;
    logic        in_frame;
    logic [4:0]  bit_count;
    logic [26:0] bits_q;
    i2c_frame_t  rx_frames [64];
    logic [2:0]  rx_acks [64];
    logic [5:0]  rx_count;

    codec_init_top codec_init_top_inst (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_start    (i_start),
        .i_sdat     (i_sdat),
        .o_sclk     (o_sclk),
        .o_sdat     (o_sdat),
        .o_oen      (o_oen),
        .o_finished (o_finished),
        .o_error    (o_error)
    );

    initial begin
        i_clk = 1'b0;
        forever #5 i_clk = ~i_clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic int unsigned rand_below(input int unsigned n);
        rng_state = xorshift32(rng_state);
        return rng_state % n;
    endfunction

    // Every ninth bit-slot belongs to the device
    function automatic logic ack_slot(input logic [4:0] n);
        return (n != 5'd0) && ((n % 5'd9) == 5'd0);
    endfunction

    function automatic i2c_frame_t expected_frame(input logic [2:0] n);
        i2c_frame_t f;
        f.dev_byte  = 8'h34;
        f.reg_byte  = {MODEL_ADDR[n], MODEL_VALUE[n][8]};
        f.data_byte = MODEL_VALUE[n][7:0];
        return f;
    endfunction

    task automatic report_failure();
        $display("TEST FAILED");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic fail_with(input string what);
        $display("ERROR: %s", what);
        report_failure();
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (expected === actual) else begin
            $display("MISMATCH %s expected 0x%0h actual 0x%0h", name, expected, actual);
            report_failure();
        end
    endtask

    always @(posedge i_clk) begin
        cycle_count <= cycle_count + 1;
        assert (cycle_count < TIMEOUT_CYCLES)
        else fail_with("timeout, the runs did not complete in the expected number of cycles");
    end

    // Device pulls the line low in ack slots, high for the chosen NACK
    always @(posedge i_clk) begin
        if (!i_rst_n) begin
            dev_oen_q <= 1'b1;
            ack_total <= '0;
            i_sdat    <= 1'b1;
        end else begin
            if (!o_oen) begin
                if (dev_oen_q) begin    // First cycle of a new ack slot
                    ack_total <= ack_total + 8'd1;
                    i_sdat    <= nack_armed && (ack_total == nack_target);
                end
            end else begin
                i_sdat <= o_sdat;
            end
            dev_oen_q <= o_oen;
        end
    end

    always @(posedge i_clk) begin
        if (!i_rst_n) begin
            mon_sclk_q <= 1'b1;
            mon_sdat_q <= 1'b1;
            mon_oen_q  <= 1'b1;
            in_frame   <= 1'b0;
            bit_count  <= '0;
            bits_q     <= '0;
            rx_count   <= '0;
        end else begin
            if (mon_oen_q && o_oen && mon_sclk_q && o_sclk && (o_sdat != mon_sdat_q)) begin
                if (!o_sdat) begin
                    assert (!in_frame) else fail_with("start condition inside a frame");
                    in_frame  <= 1'b1;
                    bit_count <= '0;
                end else begin
                    assert (in_frame && (bit_count == 5'd27))
                    else fail_with("stop condition before all 27 bit-slots were sent");
                    in_frame <= 1'b0;
                    rx_frames[rx_count] <= {bits_q[26:19], bits_q[17:10], bits_q[8:1]};
                    rx_acks[rx_count]   <= {bits_q[18], bits_q[9], bits_q[0]};
                    rx_count            <= rx_count + 6'd1;
                end
            end else if (!mon_sclk_q && o_sclk) begin
                assert (in_frame && (bit_count < 5'd27))
                else fail_with("clock pulse outside a frame or beyond bit-slot 27");
                check_value("ack_release_high", 32'(!ack_slot(bit_count + 5'd1)), 32'(o_oen));
                bit_count <= bit_count + 5'd1;
                bits_q    <= {bits_q[25:0], (o_oen ? o_sdat : i_sdat)};
            end else if (mon_sclk_q && !o_sclk) begin
                check_value("ack_release_end", 32'(!ack_slot(bit_count)), 32'(mon_oen_q));
            end

            if (in_frame && !o_sclk) begin
                check_value("ack_release_low", 32'(!ack_slot(bit_count + 5'd1)), 32'(o_oen));
            end

            mon_sclk_q <= o_sclk;
            mon_sdat_q <= o_sdat;
            mon_oen_q  <= o_oen;
        end
    end

    task automatic check_reset_state();
        repeat (3) begin
            @(posedge i_clk);
            check_value("reset_bus", 32'h7, 32'({o_sclk, o_sdat, o_oen}));
            check_value("reset_levels", 32'h0, 32'({o_finished, o_error}));
        end
    endtask

    // One start edge, then check the frames against the model
    task automatic do_run(input int run);
        int unsigned mode;
        int unsigned hold;
        int unsigned inject;
        int unsigned nack_frame;
        int unsigned nack_slot;
        int unsigned expect_frames;
        logic [5:0]  rx_base;
        logic [2:0]  exp_acks;

        repeat (rand_below(GAP_MAX) + 1) @(posedge i_clk);
        mode       = (run < 3) ? run : rand_below(3);   // 0 pulse, 1 held, 2 pulsed twice
        inject     = (run == 1) ? 1 : ((run == 0) || (run == 2)) ? 0 : rand_below(2);
        nack_frame = rand_below(`INIT_NUM_REGS);
        nack_slot  = rand_below(3);
        hold       = 3 + rand_below(FRAME_CYCLES / 4);
        expect_frames = (inject != 0) ? nack_frame + 1 : `INIT_NUM_REGS;

        rx_base     = rx_count;
        nack_armed  <= (inject != 0);
        nack_target <= ack_total + 8'(nack_frame * 3 + nack_slot);
        i_start     <= 1'b1;
        repeat (3) @(posedge i_clk);
        check_value("levels_cleared", 32'h0, 32'({o_finished, o_error}));

        if (mode != 1) begin
            repeat (hold - 3) @(posedge i_clk);
            i_start <= 1'b0;
            if (mode == 2) begin
                // Second edge lands inside the first frame
                repeat (rand_below(FRAME_CYCLES / 4) + 1) @(posedge i_clk);
                i_start <= 1'b1;
                repeat (2) @(posedge i_clk);
                i_start <= 1'b0;
            end
        end

        while (!(o_finished || o_error)) @(posedge i_clk);
        i_start <= 1'b0;
        repeat (2 * PHASE + 8) @(posedge i_clk);   // Room for a stray frame to show up

        check_value("frame_count", 32'(expect_frames), 32'(rx_count - rx_base));
        check_value("bus_idle", 32'h0, 32'(in_frame));
        check_value("bus_released", 32'h7, 32'({o_sclk, o_sdat, o_oen}));
        for (int i = 0; i < expect_frames; i++) begin
            exp_acks = ((inject != 0) && (i == nack_frame)) ? (3'b100 >> nack_slot) : 3'b000;
            check_value($sformatf("run%0d_frame%0d", run, i),
                        32'(expected_frame(3'(i))), 32'(rx_frames[rx_base + 6'(i)]));
            check_value($sformatf("run%0d_acks%0d", run, i),
                        32'(exp_acks), 32'(rx_acks[rx_base + 6'(i)]));
        end
        check_value("finished", 32'(inject == 0), 32'(o_finished));
        check_value("error", 32'(inject != 0), 32'(o_error));
        nack_armed <= 1'b0;
    endtask

    initial begin
        i_rst_n = 1'b0;
        i_start = 1'b0;
        repeat (2) @(posedge i_clk);
        i_rst_n <= 1'b1;

        check_reset_state();
        for (int run = 0; run < NUM_RUNS; run++) begin
            do_run(run);
        end

        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
+incdir+.
codec_init_pkg.sv
i2c_word_if.sv
i2c_write_engine.sv
codec_init_sequencer.sv
codec_init_top.sv
tb_codec_init.sv

// File: Makefile
VERILATOR ?= verilator
TOP       := tb_codec_init
FILELIST  := build.f
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
OBJ_DIR   := obj_dir

SIM       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(filter-out +%,$(shell cat $(FILELIST))) init_defs.svh

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# A $$fatal in the testbench gives a non-zero exit status
run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)
